/* all.f */
+incdir+logic
logic/tri_inv_pkg.sv
logic/tri_inv_ifs.sv
logic/complex_recip.sv
logic/complex_mac.sv
logic/tri_inv_ctrl.sv
logic/tri_inv_top.sv
tb/tri_inv_properties.sv
tb/tri_inv_tb.sv

/* logic/complex_mac.sv */
`include "tri_inv_settings.svh"

module complex_mac (
  input logic clk,
  input logic rst_ni,
  mac_if.unit port
);

  logic signed [2*`TRI_W-1:0] p_rr;
  logic signed [2*`TRI_W-1:0] p_ii;
  logic signed [2*`TRI_W-1:0] p_ri;
  logic signed [2*`TRI_W-1:0] p_ir;
  logic signed [`TRI_ACC_W-1:0] prod_re;
  logic signed [`TRI_ACC_W-1:0] prod_im;
  logic signed [`TRI_ACC_W-1:0] acc_re_q;
  logic signed [`TRI_ACC_W-1:0] acc_im_q;

  // shift out the fraction, clamp symmetric
  function automatic logic signed [`TRI_W-1:0] sat_acc(input logic signed [`TRI_ACC_W-1:0] v);
    logic signed [`TRI_ACC_W-1:0] s;
    s = v >>> `TRI_FRAC;
    if (s > (2**(`TRI_W-1) - 1)) begin
      return 2**(`TRI_W-1) - 1;
    end else if (s < -(2**(`TRI_W-1) - 1)) begin
      return -(2**(`TRI_W-1) - 1);
    end
    return s[`TRI_W-1:0];
  endfunction

  assign p_rr = port.a.re * port.b.re;
  assign p_ii = port.a.im * port.b.im;
  assign p_ri = port.a.re * port.b.im;
  assign p_ir = port.a.im * port.b.re;

  assign prod_re = p_rr - p_ii;
  assign prod_im = p_ri + p_ir;

  always_ff @(posedge clk) begin
    if (!rst_ni) begin
      acc_re_q <= '0;
      acc_im_q <= '0;
    end else if (port.en) begin
      acc_re_q <= (port.clear ? '0 : acc_re_q) + prod_re;
      acc_im_q <= (port.clear ? '0 : acc_im_q) + prod_im;
    end
  end

  assign port.acc_out.re = sat_acc(acc_re_q);
  assign port.acc_out.im = sat_acc(acc_im_q);

endmodule

/* logic/complex_recip.sv */
`include "tri_inv_settings.svh"

module complex_recip (
  input logic  clk,
  input logic  rst_ni,
  recip_if.unit port
);

  logic                          busy_q;
  logic                          valid_q;
  logic [$clog2(2*`TRI_W+1)-1:0] cnt_q;
  logic [4*`TRI_W:0]             st_re_q;  // {remainder, dividend/quotient}
  logic [4*`TRI_W:0]             st_im_q;
  logic [2*`TRI_W:0]             den_q;
  logic                          neg_re_q;
  logic                          neg_im_q;
  logic                          sing_q;
  tri_inv_pkg::cplx_t            res_q;

  logic signed [2*`TRI_W-1:0]    re_sq;
  logic signed [2*`TRI_W-1:0]    im_sq;
  logic [2*`TRI_W-1:0]           mag_sq;
  logic [`TRI_W-1:0]             abs_re;
  logic [`TRI_W-1:0]             abs_im;
  logic                          accept;

  // one restoring step, shifts a quotient bit in at the bottom
  function automatic logic [4*`TRI_W:0] div_step(input logic [4*`TRI_W:0] st,
                                                 input logic [2*`TRI_W:0] den);
    logic [4*`TRI_W:0] sh;
    sh = st << 1;
    if (sh[4*`TRI_W -: 2*`TRI_W+1] >= den) begin
      sh[4*`TRI_W -: 2*`TRI_W+1] = sh[4*`TRI_W -: 2*`TRI_W+1] - den;
      sh[0] = 1'b1;
    end
    return sh;
  endfunction

  function automatic logic signed [`TRI_W-1:0] sat_sign(input logic [2*`TRI_W-1:0] q,
                                                        input logic neg);
    logic signed [`TRI_W-1:0] mag;
    if (q > (2**(`TRI_W-1) - 1)) begin
      mag = 2**(`TRI_W-1) - 1;
    end else begin
      mag = q[`TRI_W-1:0];
    end
    return neg ? -mag : mag;
  endfunction

  assign accept = port.in_valid && !busy_q;

  assign re_sq  = port.operand.re * port.operand.re;
  assign im_sq  = port.operand.im * port.operand.im;
  assign mag_sq = re_sq + im_sq;  // fits unsigned, up to 2**(2W-1)
  assign abs_re = port.operand.re[`TRI_W-1] ? -port.operand.re : port.operand.re;
  assign abs_im = port.operand.im[`TRI_W-1] ? -port.operand.im : port.operand.im;

  always_ff @(posedge clk) begin
    if (!rst_ni) begin
      busy_q  <= 1'b0;
      valid_q <= 1'b0;
      cnt_q   <= '0;
    end else if (port.flush) begin
      busy_q  <= 1'b0;
      valid_q <= 1'b0;
      cnt_q   <= '0;
    end else begin
      valid_q <= 1'b0;
      if (accept) begin
        busy_q <= 1'b1;
        cnt_q  <= '0;
      end else if (busy_q) begin
        if (cnt_q == 2*`TRI_W) begin
          busy_q  <= 1'b0;
          valid_q <= 1'b1;
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      st_re_q  <= (4*`TRI_W+1)'(abs_re) << (2*`TRI_FRAC);
      st_im_q  <= (4*`TRI_W+1)'(abs_im) << (2*`TRI_FRAC);
      den_q    <= {1'b0, mag_sq};
      neg_re_q <= port.operand.re[`TRI_W-1];
      neg_im_q <= ~port.operand.im[`TRI_W-1];  // numerator is -im
      sing_q   <= (mag_sq == '0);
    end else if (busy_q && cnt_q != 2*`TRI_W) begin
      st_re_q <= div_step(st_re_q, den_q);
      st_im_q <= div_step(st_im_q, den_q);
    end else if (busy_q) begin
      res_q.re <= sat_sign(st_re_q[2*`TRI_W-1:0], neg_re_q);
      res_q.im <= sat_sign(st_im_q[2*`TRI_W-1:0], neg_im_q);
    end
  end

  assign port.in_ready  = !busy_q;
  assign port.out_valid = valid_q;
  assign port.result    = res_q;
  assign port.singular  = sing_q;

endmodule

/* logic/tri_inv_ctrl.sv */
`include "tri_inv_settings.svh"

module tri_inv_ctrl (
  input  logic                                 clk,
  input  logic                                 rst_ni,
  input  logic                                 start_i,
  input  logic                                 flush_i,
  input  tri_inv_pkg::cplx_t [`TRI_N-1:0]      mat_row_i,
  input  logic                                 mat_row_valid_i,
  input  logic [$clog2(`TRI_N)-1:0]            mat_row_addr_i,
  output logic                                 mat_row_req_o,
  output logic [$clog2(`TRI_N)-1:0]            mat_row_addr_o,
  output tri_inv_pkg::cplx_t [`TRI_N-1:0]      inv_row_o,
  output logic [$clog2(`TRI_N)-1:0]            inv_row_addr_o,
  output logic                                 inv_row_valid_o,
  output logic                                 busy_o,
  output logic                                 error_o,
  recip_if.ctrl                                recip,
  mac_if.ctrl                                  mac
);

  typedef logic [$clog2(`TRI_N)-1:0] idx_t;
  typedef enum logic [1:0] {STEP_ACC, STEP_MUL, STEP_STORE} step_t;

  tri_inv_pkg::state_t state_q;
  step_t               step_q;
  idx_t                idx_q;  // row address in FETCH, DIAG and OUT
  idx_t                i_q;
  idx_t                j_q;
  idx_t                k_q;
  logic                sent_q;  // diagonal operand handed to recip unit

  tri_inv_pkg::cplx_t  l_bank [`TRI_N][`TRI_N];
  tri_inv_pkg::cplx_t  x_bank [`TRI_N][`TRI_N];
  tri_inv_pkg::cplx_t  diag_q [`TRI_N];
  tri_inv_pkg::cplx_t  x_kj;
  tri_inv_pkg::cplx_t  x_new;
  logic                row_hit;

  assign row_hit = mat_row_valid_i && (mat_row_addr_i == idx_q);
  assign x_kj    = (k_q == j_q) ? diag_q[j_q] : x_bank[k_q][j_q];
  assign x_new.re = -mac.acc_out.re;
  assign x_new.im = -mac.acc_out.im;

  assign recip.operand  = l_bank[idx_q][idx_q];
  assign recip.in_valid = (state_q == tri_inv_pkg::DIAG) && !sent_q;
  assign recip.flush    = flush_i;

  always_comb begin
    mac.a     = l_bank[i_q][k_q];
    mac.b     = x_kj;
    mac.en    = 1'b0;
    mac.clear = 1'b0;
    if (state_q == tri_inv_pkg::INV) begin
      if (step_q == STEP_ACC) begin
        mac.en    = 1'b1;
        mac.clear = (k_q == j_q);  // first term of the sum
      end else if (step_q == STEP_MUL) begin
        mac.a     = diag_q[i_q];
        mac.b     = mac.acc_out;
        mac.en    = 1'b1;
        mac.clear = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_ni) begin
      state_q <= tri_inv_pkg::IDLE;
      step_q  <= STEP_ACC;
      idx_q   <= '0;
      i_q     <= '0;
      j_q     <= '0;
      k_q     <= '0;
      sent_q  <= 1'b0;
    end else if (flush_i) begin
      state_q <= tri_inv_pkg::IDLE;
      sent_q  <= 1'b0;
    end else begin
      case (state_q)
        tri_inv_pkg::IDLE: begin
          if (start_i) begin
            state_q <= tri_inv_pkg::FETCH;
            idx_q   <= '0;
          end
        end
        tri_inv_pkg::FETCH: begin
          if (row_hit) begin
            idx_q <= idx_q + 1'b1;  // wraps to 0 after the last row
            if (idx_q == idx_t'(`TRI_N-1)) state_q <= tri_inv_pkg::DIAG;
          end
        end
        tri_inv_pkg::DIAG: begin
          if (recip.in_valid && recip.in_ready) sent_q <= 1'b1;
          if (recip.out_valid) begin
            sent_q <= 1'b0;
            idx_q  <= idx_q + 1'b1;
            if (recip.singular) begin
              state_q <= tri_inv_pkg::FAIL;
            end else if (idx_q == idx_t'(`TRI_N-1)) begin
              state_q <= tri_inv_pkg::INV;
              step_q  <= STEP_ACC;
              j_q     <= '0;
              i_q     <= idx_t'(1);
              k_q     <= '0;
            end
          end
        end
        tri_inv_pkg::INV: begin
          case (step_q)
            STEP_ACC: begin
              k_q <= k_q + 1'b1;
              if (k_q == i_q - 1'b1) step_q <= STEP_MUL;
            end
            STEP_MUL: step_q <= STEP_STORE;
            default: begin
              step_q <= STEP_ACC;
              if (i_q == idx_t'(`TRI_N-1)) begin
                if (j_q == idx_t'(`TRI_N-2)) begin
                  state_q <= tri_inv_pkg::OUT;
                  idx_q   <= '0;
                end else begin
                  j_q <= j_q + 1'b1;
                  i_q <= j_q + 2'd2;
                  k_q <= j_q + 1'b1;
                end
              end else begin
                i_q <= i_q + 1'b1;
                k_q <= j_q;
              end
            end
          endcase
        end
        tri_inv_pkg::OUT: begin
          idx_q <= idx_q + 1'b1;
          if (idx_q == idx_t'(`TRI_N-1)) state_q <= tri_inv_pkg::IDLE;
        end
        default: state_q <= tri_inv_pkg::IDLE;  // FAIL lasts one cycle
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == tri_inv_pkg::FETCH && row_hit) begin
      for (int c = 0; c < `TRI_N; c++) begin
        if (idx_t'(c) <= idx_q) l_bank[idx_q][c] <= mat_row_i[c];  // lower triangle only
      end
    end
    if (state_q == tri_inv_pkg::DIAG && recip.out_valid) diag_q[idx_q] <= recip.result;
    if (state_q == tri_inv_pkg::INV && step_q == STEP_STORE) x_bank[i_q][j_q] <= x_new;
  end

  always_comb begin
    for (int c = 0; c < `TRI_N; c++) begin
      if (idx_t'(c) == idx_q) begin
        inv_row_o[c] = diag_q[idx_q];
      end else if (idx_t'(c) < idx_q) begin
        inv_row_o[c] = x_bank[idx_q][c];
      end else begin
        inv_row_o[c] = '0;
      end
    end
  end

  assign mat_row_req_o   = (state_q == tri_inv_pkg::FETCH);
  assign mat_row_addr_o  = idx_q;
  assign inv_row_addr_o  = idx_q;
  assign inv_row_valid_o = (state_q == tri_inv_pkg::OUT);
  assign busy_o          = (state_q != tri_inv_pkg::IDLE);
  assign error_o         = (state_q == tri_inv_pkg::FAIL);

endmodule

/* logic/tri_inv_ifs.sv */
interface recip_if;
  tri_inv_pkg::cplx_t operand;
  logic               in_valid;
  logic               in_ready;
  tri_inv_pkg::cplx_t result;
  logic               out_valid;
  logic               singular;  // valid with out_valid
  logic               flush;

  modport ctrl (
    output operand, in_valid, flush,
    input  in_ready, result, out_valid, singular
  );

  modport unit (
    input  operand, in_valid, flush,
    output in_ready, result, out_valid, singular
  );
endinterface

interface mac_if;
  tri_inv_pkg::cplx_t a;
  tri_inv_pkg::cplx_t b;
  logic               en;
  logic               clear;    // add product to zero instead of old sum
  tri_inv_pkg::cplx_t acc_out;  // saturated readout

  modport ctrl (
    output a, b, en, clear,
    input  acc_out
  );

  modport unit (
    input  a, b, en, clear,
    output acc_out
  );
endinterface

/* logic/tri_inv_pkg.sv */
`include "tri_inv_settings.svh"

package tri_inv_pkg;

  typedef struct packed {
    logic signed [`TRI_W-1:0] re;
    logic signed [`TRI_W-1:0] im;
  } cplx_t;

  typedef enum logic [2:0] {
    IDLE,   // waiting for start
    FETCH,  // loading rows of L
    DIAG,   // reciprocal of each diagonal element
    INV,    // forward substitution
    OUT,    // streaming rows of X
    FAIL    // singular matrix, one cycle
  } state_t;

endpackage

/* logic/tri_inv_settings.svh */
`ifndef TRI_INV_SETTINGS_SVH
`define TRI_INV_SETTINGS_SVH

// matrix dimension
`define TRI_N 4

// width of each real or imaginary part, signed
`define TRI_W 16

// fraction bits, value = v / 2**TRI_FRAC
`define TRI_FRAC 12

// mac accumulator width per part
`define TRI_ACC_W (2*`TRI_W+4)

`endif

/* logic/tri_inv_top.sv */
`include "tri_inv_settings.svh"

module tri_inv_top (
  input  logic                            clk,
  input  logic                            rst_ni,
  input  logic                            start_i,
  input  logic                            flush_i,
  input  tri_inv_pkg::cplx_t [`TRI_N-1:0] mat_row_i,
  input  logic                            mat_row_valid_i,
  input  logic [$clog2(`TRI_N)-1:0]       mat_row_addr_i,
  output logic                            mat_row_req_o,
  output logic [$clog2(`TRI_N)-1:0]       mat_row_addr_o,
  output tri_inv_pkg::cplx_t [`TRI_N-1:0] inv_row_o,
  output logic [$clog2(`TRI_N)-1:0]       inv_row_addr_o,
  output logic                            inv_row_valid_o,
  output logic                            busy_o,
  output logic                            error_o
);

  recip_if recip_bus ();
  mac_if   mac_bus ();

  tri_inv_ctrl u_ctrl (
    .clk             (clk),
    .rst_ni          (rst_ni),
    .start_i         (start_i),
    .flush_i         (flush_i),
    .mat_row_i       (mat_row_i),
    .mat_row_valid_i (mat_row_valid_i),
    .mat_row_addr_i  (mat_row_addr_i),
    .mat_row_req_o   (mat_row_req_o),
    .mat_row_addr_o  (mat_row_addr_o),
    .inv_row_o       (inv_row_o),
    .inv_row_addr_o  (inv_row_addr_o),
    .inv_row_valid_o (inv_row_valid_o),
    .busy_o          (busy_o),
    .error_o         (error_o),
    .recip           (recip_bus.ctrl),
    .mac             (mac_bus.ctrl)
  );

  complex_recip u_recip (
    .clk    (clk),
    .rst_ni (rst_ni),
    .port   (recip_bus.unit)
  );

  complex_mac u_mac (
    .clk    (clk),
    .rst_ni (rst_ni),
    .port   (mac_bus.unit)
  );

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tri_inv_tb
./obj_dir/Vtri_inv_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "SIMULATION PASSED" sim.log; then
  exit 0
fi
exit 1

/* tb/tri_inv_properties.sv */
module tri_inv_properties (
  input logic               clk,
  input logic               rst_ni,
  input logic               busy_o,
  input logic               error_o,
  input logic               inv_row_valid_o,
  input logic               mat_row_req_o,
  input tri_inv_pkg::cplx_t recip_operand,
  input logic               recip_in_valid,
  input logic               recip_in_ready
);

  int unsigned fails = 0;  // read by the testbench at the end

  valid_needs_busy: assert property (@(posedge clk) disable iff (!rst_ni)
    inv_row_valid_o |-> busy_o)
    else begin
      fails++;
      $error("inv_row_valid_o high while busy_o is low");
    end

  error_not_with_rows: assert property (@(posedge clk) disable iff (!rst_ni)
    !(error_o && inv_row_valid_o))
    else begin
      fails++;
      $error("error_o and inv_row_valid_o high together");
    end

  req_only_when_busy: assert property (@(posedge clk) disable iff (!rst_ni)
    !busy_o |-> !mat_row_req_o)
    else begin
      fails++;
      $error("mat_row_req_o high while idle");
    end

  operand_held: assert property (@(posedge clk) disable iff (!rst_ni)
    recip_in_valid && !recip_in_ready |=> $stable(recip_operand))
    else begin
      fails++;
      $error("recip operand changed before the transfer");
    end

endmodule

bind tri_inv_top tri_inv_properties props0 (
  .clk             (clk),
  .rst_ni          (rst_ni),
  .busy_o          (busy_o),
  .error_o         (error_o),
  .inv_row_valid_o (inv_row_valid_o),
  .mat_row_req_o   (mat_row_req_o),
  .recip_operand   (recip_bus.operand),
  .recip_in_valid  (recip_bus.in_valid),
  .recip_in_ready  (recip_bus.in_ready)
);

/* tb/tri_inv_tb.sv */
`include "tri_inv_settings.svh"

module tri_inv_tb;

  localparam int N         = `TRI_N;
  localparam int NUM_TESTS = 29;
  localparam int LIMIT     = NUM_TESTS * N * N * (2*`TRI_W + 40) + 1000;
  localparam longint MAXV  = (longint'(1) << (`TRI_W-1)) - 1;

  logic                       clk = 1'b0;
  logic                       rst_ni;
  logic                       start_i;
  logic                       flush_i;
  tri_inv_pkg::cplx_t [N-1:0] mat_row_i;
  logic                       mat_row_valid_i;
  logic [$clog2(N)-1:0]       mat_row_addr_i;
  logic                       mat_row_req_o;
  logic [$clog2(N)-1:0]       mat_row_addr_o;
  tri_inv_pkg::cplx_t [N-1:0] inv_row_o;
  logic [$clog2(N)-1:0]       inv_row_addr_o;
  logic                       inv_row_valid_o;
  logic                       busy_o;
  logic                       error_o;

  int seed       = 29;
  int max_delay  = 0;
  int wrong_mode = 0;  // 0 never, 1 sometimes, 2 always
  int value_errs = 0;
  int other_errs = 0;
  int rows_seen  = 0;
  int err_cycles = 0;
  bit prev_valid = 1'b0;
  int lr [N][N];  // matrix L, real and imaginary parts
  int li [N][N];
  int er [N][N];  // expected inverse
  int ei [N][N];

  always #4 clk = ~clk;

  tri_inv_top dut0 (.*);

  function automatic int sat(input longint v);
    if (v > MAXV) return int'(MAXV);
    if (v < -MAXV) return int'(-MAXV);
    return int'(v);
  endfunction

  function automatic int rand_val(input int span);
    return $random(seed) % span;
  endfunction

  // fills er/ei, returns 1 for a zero diagonal element
  function automatic bit ref_inverse();
    longint d;
    longint sr;
    longint si;
    int     s_re;
    int     s_im;
    for (int i = 0; i < N; i++) begin
      for (int j = 0; j < N; j++) begin
        er[i][j] = 0;
        ei[i][j] = 0;
      end
      d = longint'(lr[i][i]) * lr[i][i] + longint'(li[i][i]) * li[i][i];
      if (d == 0) return 1'b1;
      er[i][i] = sat((longint'(lr[i][i]) <<< (2*`TRI_FRAC)) / d);
      ei[i][i] = sat((-longint'(li[i][i]) <<< (2*`TRI_FRAC)) / d);
    end
    for (int j = 0; j < N - 1; j++) begin
      for (int i = j + 1; i < N; i++) begin
        sr = 0;
        si = 0;
        for (int k = j; k < i; k++) begin
          sr += longint'(lr[i][k]) * er[k][j] - longint'(li[i][k]) * ei[k][j];
          si += longint'(lr[i][k]) * ei[k][j] + longint'(li[i][k]) * er[k][j];
        end
        s_re = sat(sr >>> `TRI_FRAC);
        s_im = sat(si >>> `TRI_FRAC);
        sr = longint'(er[i][i]) * s_re - longint'(ei[i][i]) * s_im;
        si = longint'(er[i][i]) * s_im + longint'(ei[i][i]) * s_re;
        er[i][j] = -sat(sr >>> `TRI_FRAC);  // negate after saturation
        ei[i][j] = -sat(si >>> `TRI_FRAC);
      end
    end
    return 1'b0;
  endfunction

  // kind 0 identity, 1 random, 2 random with tiny diagonal
  task automatic fill_matrix(input int kind);
    for (int r = 0; r < N; r++) begin
      for (int c = 0; c < N; c++) begin
        lr[r][c] = rand_val(c > r ? 32768 : (c == r ? 8192 : 4096));  // junk above diagonal
        li[r][c] = rand_val(c > r ? 32768 : (c == r ? 8192 : 4096));
        if (c == r && lr[r][c] == 0 && li[r][c] == 0) lr[r][c] = 1 << `TRI_FRAC;
        if (kind == 0) begin
          lr[r][c] = (r == c) ? (1 << `TRI_FRAC) : 0;
          li[r][c] = 0;
        end
      end
      if (kind == 2) begin
        lr[r][r] = (r % 4 == 2) ? -1 : (r % 4 == 1 ? 0 : r % 4 + 1);
        li[r][r] = (r % 4 == 1) ? -1 : (r % 4 == 2 ? 1 : 0);
      end
    end
  endtask

  task automatic pulse_start();
    rows_seen  = 0;
    err_cycles = 0;
    @(posedge clk);
    start_i <= 1'b1;
    @(posedge clk);
    start_i <= 1'b0;
  endtask

  task automatic run_matrix(input int delay_span, input int wrong);
    bit singular;
    int waited;
    singular   = ref_inverse();
    max_delay  = delay_span;
    wrong_mode = wrong;
    pulse_start();
    waited = 0;
    @(negedge clk);
    while (busy_o && waited < 2000) begin
      @(negedge clk);
      waited++;
    end
    if (busy_o) begin
      $display("busy_o did not fall within 2000 cycles");
      other_errs++;
    end
    if (rows_seen != (singular ? 0 : N) || err_cycles != (singular ? 1 : 0)) begin
      $display("run gave %0d rows and %0d error cycles, expected %0d and %0d",
               rows_seen, err_cycles, singular ? 0 : N, singular ? 1 : 0);
      other_errs++;
    end
  endtask

  task automatic abort_run();
    int waited;
    pulse_start();
    waited = 0;
    @(negedge clk);
    while (mat_row_req_o && waited < 2000) begin
      @(negedge clk);
      waited++;
    end
    repeat (20) @(posedge clk);  // reciprocal unit is busy now
    flush_i <= 1'b1;
    @(posedge clk);
    flush_i <= 1'b0;
    @(negedge clk);
    if (busy_o) begin
      $display("busy_o still high one cycle after flush_i");
      other_errs++;
    end
    repeat (50) @(negedge clk);
    if (busy_o || rows_seen != 0 || err_cycles != 0) begin
      $display("flushed run still produced output or stayed busy");
      other_errs++;
    end
  endtask

  initial begin : answer_rows
    int a;
    int d;
    forever begin
      @(negedge clk);
      if (mat_row_req_o) begin
        a = mat_row_addr_o;
        d = $unsigned($random(seed)) % (max_delay + 1);
        repeat (d) @(posedge clk);
        @(posedge clk);
        if (wrong_mode == 2 || (wrong_mode == 1 && $random(seed) % 3 == 0)) begin
          mat_row_valid_i <= 1'b1;
          mat_row_addr_i  <= a + 1;  // never the requested row
          for (int c = 0; c < N; c++) mat_row_i[c] <= $random(seed);
          @(posedge clk);
        end
        mat_row_valid_i <= 1'b1;
        mat_row_addr_i  <= a;
        for (int c = 0; c < N; c++) begin
          mat_row_i[c].re <= lr[a][c];
          mat_row_i[c].im <= li[a][c];
        end
        @(posedge clk);
        mat_row_valid_i <= 1'b0;
      end
    end
  end

  initial begin : compare_rows
    int got_re;
    int got_im;
    forever begin
      @(negedge clk);
      if (error_o) err_cycles++;
      if (inv_row_valid_o && rows_seen >= N) begin
        $display("more than %0d output rows in one run", N);
        other_errs++;
      end else if (inv_row_valid_o) begin
        if (rows_seen > 0 && !prev_valid) begin
          $display("output rows were not sent on consecutive cycles");
          other_errs++;
        end
        if (inv_row_addr_o != rows_seen) begin
          $display("[ERROR] %0t inv_row_addr_o expected %0d actual %0d",
                   $time, rows_seen, inv_row_addr_o);
          value_errs++;
        end
        for (int c = 0; c < N; c++) begin
          got_re = inv_row_o[c].re;
          got_im = inv_row_o[c].im;
          if (got_re != er[rows_seen][c]) begin
            $display("[ERROR] %0t inv_row_o[%0d][%0d].re expected %0d actual %0d",
                     $time, rows_seen, c, er[rows_seen][c], got_re);
            value_errs++;
          end
          if (got_im != ei[rows_seen][c]) begin
            $display("[ERROR] %0t inv_row_o[%0d][%0d].im expected %0d actual %0d",
                     $time, rows_seen, c, ei[rows_seen][c], got_im);
            value_errs++;
          end
        end
      end
      if (inv_row_valid_o) rows_seen++;
      prev_valid = inv_row_valid_o;
    end
  end

  initial begin : watchdog
    repeat (LIMIT) @(posedge clk);
    $display("timeout after %0d cycles, the run did not finish", LIMIT);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin : run_tests
    rst_ni          <= 1'b0;
    start_i         <= 1'b0;
    flush_i         <= 1'b0;
    mat_row_valid_i <= 1'b0;
    mat_row_addr_i  <= '0;
    mat_row_i       <= '0;
    repeat (16) @(posedge clk);
    rst_ni <= 1'b1;
    @(negedge clk);
    if (busy_o || error_o || inv_row_valid_o || mat_row_req_o) begin
      $display("outputs not low after reset");
      other_errs++;
    end
    fill_matrix(0);
    run_matrix(0, 0);
    repeat (20) begin
      fill_matrix(1);
      run_matrix(5, 1);
    end
    repeat (2) begin  // same matrix, prompt then slow with wrong rows
      fill_matrix(1);
      run_matrix(0, 0);
      run_matrix(5, 2);
    end
    fill_matrix(1);
    lr[N/2][N/2] = 0;
    li[N/2][N/2] = 0;
    run_matrix(2, 1);
    fill_matrix(1);
    abort_run();
    fill_matrix(1);
    run_matrix(2, 1);
    fill_matrix(2);
    run_matrix(1, 1);
    repeat (5) @(posedge clk);
    other_errs += dut0.props0.fails;
    $display("error counts: %0d value, %0d other", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
